/* logic/ex_macros.svh */
/*
 * Execute stage widths and fixed encodings
 */

`ifndef EX_MACROS_SVH
`define EX_MACROS_SVH

//////////////////////////////
// Datapath widths
//////////////////////////////

`define EX_XLEN        32
`define EX_REG_ADDR_W  5
`define EX_CSR_ADDR_W  12
`define EX_SHAMT_W     5

// Upper bits of operand 2 left over by the CSR view
`define EX_CSR_PAD_W   (`EX_XLEN - `EX_CSR_ADDR_W)

//////////////////////////////
// Encoding widths
//////////////////////////////

`define EX_ALU_OP_W    4
`define EX_PC_SRC_W    2
`define EX_DTYPE_W     2
`define EX_CSR_OP_W    2

// Target bit that must be clear without compressed instructions
`define EX_MISALIGN_BIT 1

`endif

/* logic/ex_pkg.sv */
/*
 * Execute stage types
 * Operation encodings, the ID bundle and the CSR request
 */

`include "ex_macros.svh"

package ex_pkg;

    // ALU operations, compares return 0 or 1 in bit 0
    typedef enum logic [`EX_ALU_OP_W-1:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLL,
        ALU_SRL,
        ALU_SRA,
        ALU_SLT,
        ALU_SLTU,
        ALU_EQ,
        ALU_NE,
        ALU_LT,
        ALU_GE,
        ALU_LTU,
        ALU_GEU
    } alu_op_t;

    // Next PC selection for IF
    typedef enum logic [`EX_PC_SRC_W-1:0] {
        PC_NEXT,
        PC_BRANCH,
        PC_JUMP
    } pc_source_t;

    // Memory access size
    typedef enum logic [`EX_DTYPE_W-1:0] {
        BYTE,
        HALF,
        WORD
    } data_type_t;

    // Destination register bank
    typedef enum logic {
        X_REG,
        F_REG
    } rd_bank_t;

    typedef enum logic [`EX_CSR_OP_W-1:0] {
        CSR_READ,
        CSR_WRITE,
        CSR_SET,
        CSR_CLEAR
    } csr_op_t;

    typedef logic [`EX_CSR_ADDR_W-1:0] csr_addr_t;

    // CSR view of operand 2, address in the low bits
    typedef struct packed {
        logic [`EX_CSR_PAD_W-1:0] pad;
        csr_addr_t                addr;
    } op2_csr_view_t;

    // Operand 2 is a data word or carries a CSR address
    typedef union packed {
        logic [`EX_XLEN-1:0] word;
        op2_csr_view_t       csr;
    } operand2_u;

    // Memory control for the MEM stage
    typedef struct packed {
        logic                req;
        logic                wen;
        data_type_t          data_type;
        logic                sign_ext;
        logic [`EX_XLEN-1:0] wdata;
    } mem_ctrl_t;

    // Decoded bundle from ID
    typedef struct packed {
        logic [`EX_REG_ADDR_W-1:0] rd_addr;
        rd_bank_t                  rd_bank;
        alu_op_t                   alu_op;
        logic [`EX_XLEN-1:0]       op1;
        operand2_u                 op2;
        mem_ctrl_t                 mem;
        logic                      reg_alu_wen;
        logic                      reg_mem_wen;
        logic [`EX_XLEN-1:0]       pc;
        pc_source_t                pc_source;
        logic                      is_branch;
        logic [`EX_XLEN-1:0]       branch_target;
        logic                      csr_access;
        csr_op_t                   csr_op;
        logic                      valid;
    } id_ex_t;

    // Request towards the CSR file
    typedef struct packed {
        logic                access;
        csr_op_t             op;
        csr_addr_t           addr;
        logic [`EX_XLEN-1:0] wdata;
        logic [`EX_XLEN-1:0] pc;
    } csr_req_t;

endpackage

/* logic/ex_pipe_reg.sv */
/*
 * ID-to-EX pipeline register
 * Holds the decoded bundle under stall and loads a bubble on flush,
 * latches CSR address and write data for the CSR request
 */

`include "ex_macros.svh"

module ex_pipe_reg (
    input  logic             clk_i,
    input  logic             rst_n_i,
    input  ex_pkg::id_ex_t   id_i,
    input  logic             stall_i,
    input  logic             flush_i,
    output ex_pkg::id_ex_t   ex_q_o,
    output ex_pkg::csr_req_t csr_o
);

    // Registered bundle
    ex_pkg::id_ex_t ex_q;

    // CSR request payload, loaded only on CSR accesses
    ex_pkg::csr_addr_t   csr_addr_q;
    logic [`EX_XLEN-1:0] csr_wdata_q;

    // Load strobe for a real instruction
    logic                load_en;

    assign load_en = !stall_i && !flush_i;

    //////////////////////////////
    // Bundle register
    //////////////////////////////

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            // Everything cleared, then the non-zero encodings
            ex_q               <= '0;
            ex_q.rd_bank       <= ex_pkg::X_REG;
            ex_q.alu_op        <= ex_pkg::ALU_ADD;
            ex_q.mem.data_type <= ex_pkg::WORD;
            ex_q.pc_source     <= ex_pkg::PC_NEXT;
            ex_q.csr_op        <= ex_pkg::CSR_READ;
        end else if (!stall_i) begin
            if (flush_i) begin
                // Bubble kills side effects only
                ex_q.valid       <= 1'b0;
                ex_q.mem.req     <= 1'b0;
                ex_q.mem.wen     <= 1'b0;
                ex_q.reg_alu_wen <= 1'b0;
                ex_q.reg_mem_wen <= 1'b0;
                ex_q.is_branch   <= 1'b0;
                ex_q.csr_access  <= 1'b0;
                ex_q.csr_op      <= ex_pkg::CSR_READ;
            end else begin
                ex_q <= id_i;
            end
        end
    end

    //////////////////////////////
    // CSR request payload
    //////////////////////////////

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            csr_addr_q  <= '0;
            csr_wdata_q <= '0;
        end else if (load_en && id_i.csr_access) begin
            // wdata comes in on operand 1
            csr_wdata_q <= id_i.op1;
            // Address sits in the CSR view of operand 2
            csr_addr_q  <= id_i.op2.csr.addr;
        end
    end

    // Request fields toward the CSR file
    always_comb begin
        csr_o.access = ex_q.csr_access;
        csr_o.op     = ex_q.csr_op;
        csr_o.addr   = csr_addr_q;
        csr_o.wdata  = csr_wdata_q;
        csr_o.pc     = ex_q.pc;
    end

    assign ex_q_o = ex_q;

endmodule

/* logic/ex_alu.sv */
/*
 * Integer ALU with branch comparator
 * Compare results land in bit 0
 */

`include "ex_macros.svh"

module ex_alu (
    input  ex_pkg::alu_op_t      op_i,
    input  logic [`EX_XLEN-1:0]  op1_i,
    input  logic [`EX_XLEN-1:0]  op2_i,
    output logic [`EX_XLEN-1:0]  res_o
);

    // Signed views for SRA and signed compares
    logic signed [`EX_XLEN-1:0] op1_s;
    logic signed [`EX_XLEN-1:0] op2_s;
    logic [`EX_SHAMT_W-1:0]     shamt;
    logic                       eq;
    logic                       lt_s;
    logic                       lt_u;

    assign op1_s = op1_i;
    assign op2_s = op2_i;

    // shift amount from low bits of op2
    assign shamt = op2_i[`EX_SHAMT_W-1:0];

    // Shared compare flags
    assign eq   = (op1_i == op2_i);
    assign lt_s = (op1_s < op2_s);
    assign lt_u = (op1_i < op2_i);

    always_comb begin
        res_o = '0;
        case (op_i)
            ex_pkg::ALU_ADD:  res_o = op1_i + op2_i;
            ex_pkg::ALU_SUB:  res_o = op1_i - op2_i;
            ex_pkg::ALU_AND:  res_o = op1_i & op2_i;
            ex_pkg::ALU_OR:   res_o = op1_i | op2_i;
            ex_pkg::ALU_XOR:  res_o = op1_i ^ op2_i;
            ex_pkg::ALU_SLL:  res_o = op1_i << shamt;
            ex_pkg::ALU_SRL:  res_o = op1_i >> shamt;
            ex_pkg::ALU_SRA:  res_o = op1_s >>> shamt;
            // Set-less-than
            ex_pkg::ALU_SLT:  res_o[0] = lt_s;
            ex_pkg::ALU_SLTU: res_o[0] = lt_u;
            // Branch compares
            ex_pkg::ALU_EQ:   res_o[0] = eq;
            ex_pkg::ALU_NE:   res_o[0] = !eq;
            ex_pkg::ALU_LT:   res_o[0] = lt_s;
            ex_pkg::ALU_GE:   res_o[0] = !lt_s;
            ex_pkg::ALU_LTU:  res_o[0] = lt_u;
            ex_pkg::ALU_GEU:  res_o[0] = !lt_u;
            default:          res_o = op1_i + op2_i;
        endcase
    end

endmodule

/* logic/ex_resolve.sv */
/*
 * Execute stage result and branch resolution
 * CSR read capture, result select, branch decision, misaligned trap
 */

`include "ex_macros.svh"

module ex_resolve #(
    parameter bit C_EXT = 1'b0
) (
    input  logic                clk_i,
    input  logic                rst_n_i,
    input  logic                stall_i,
    input  logic                csr_access_id_i,
    input  logic                csr_access_i,
    input  logic [`EX_XLEN-1:0] csr_rdata_i,
    input  logic [`EX_XLEN-1:0] alu_res_i,
    input  logic                is_branch_i,
    input  logic                valid_i,
    input  logic [`EX_XLEN-1:0] branch_target_i,
    output logic [`EX_XLEN-1:0] result_o,
    output logic                branch_decision_o,
    output logic                trap_o
);

    // First cycle of a CSR access in EX
    logic                csr_cyc1_q;
    // Read data held after the first cycle
    logic [`EX_XLEN-1:0] csr_rdata_q;
    logic                misaligned;

    //////////////////////////////
    // CSR read capture
    //////////////////////////////

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            csr_cyc1_q <= 1'b0;
        end else if (stall_i) begin
            // Any stall ends the first cycle
            csr_cyc1_q <= 1'b0;
        end else begin
            csr_cyc1_q <= csr_access_id_i;
        end
    end

    // Grab the CSR file output at the end of the first cycle
    always_ff @(posedge clk_i) begin
        if (csr_cyc1_q) begin
            csr_rdata_q <= csr_rdata_i;
        end
    end

    // Live read data first, held copy while stalled
    always_comb begin
        if (csr_access_i) begin
            result_o = csr_cyc1_q ? csr_rdata_i : csr_rdata_q;
        end else begin
            result_o = alu_res_i;
        end
    end

    //////////////////////////////
    // Branch and trap
    //////////////////////////////

    // Taken when the compare returned 1
    assign branch_decision_o = is_branch_i && result_o[0];

    // Target must be word aligned unless compressed instructions exist
    assign misaligned = !C_EXT && branch_target_i[`EX_MISALIGN_BIT];

    // only a live slot may trap
    assign trap_o = valid_i && branch_decision_o && misaligned;

endmodule

/* logic/ex_stage.sv */
/*
 * Execute stage top level
 * Pipeline register, integer ALU and resolve logic for a 32-bit core
 */

`include "ex_macros.svh"

module ex_stage #(
    parameter bit C_EXT = 1'b0
) (
    input  logic                 clk_i,
    input  logic                 rst_n_i,

    // From ID
    input  ex_pkg::id_ex_t       id_i,

    // Pipeline control
    input  logic                 stall_i,
    input  logic                 flush_i,

    // From the CSR file
    input  logic [`EX_XLEN-1:0]  csr_rdata_i,

    // To MEM
    output ex_pkg::id_ex_t       ex_o,
    output logic [`EX_XLEN-1:0]  alu_result_o,

    // To the CSR file
    output ex_pkg::csr_req_t     csr_o,

    // To IF and the controller
    output logic                 branch_decision_o,
    output logic [`EX_XLEN-1:0]  branch_target_o,
    output ex_pkg::pc_source_t   pc_source_o,
    output logic                 trap_o
);

    // Registered bundle
    ex_pkg::id_ex_t      ex_q;
    // Raw ALU output before the CSR select
    logic [`EX_XLEN-1:0] alu_res;

    //////////////////////////////
    // ID-to-EX register
    //////////////////////////////

    ex_pipe_reg u_pipe_reg (
        .clk_i   (clk_i),
        .rst_n_i (rst_n_i),
        .id_i    (id_i),
        .stall_i (stall_i),
        .flush_i (flush_i),
        .ex_q_o  (ex_q),
        .csr_o   (csr_o)
    );

    //////////////////////////////
    // ALU
    //////////////////////////////

    ex_alu u_alu (
        .op_i  (ex_q.alu_op),
        .op1_i (ex_q.op1),
        .op2_i (ex_q.op2.word),
        .res_o (alu_res)
    );

    //////////////////////////////
    // Result and branch
    //////////////////////////////

    ex_resolve #(
        .C_EXT (C_EXT)
    ) u_resolve (
        .clk_i             (clk_i),
        .rst_n_i           (rst_n_i),
        .stall_i           (stall_i),
        .csr_access_id_i   (id_i.csr_access),
        .csr_access_i      (ex_q.csr_access),
        .csr_rdata_i       (csr_rdata_i),
        .alu_res_i         (alu_res),
        .is_branch_i       (ex_q.is_branch),
        .valid_i           (ex_q.valid),
        .branch_target_i   (ex_q.branch_target),
        .result_o          (alu_result_o),
        .branch_decision_o (branch_decision_o),
        .trap_o            (trap_o)
    );

    // Bundle and branch fields straight from the register
    assign ex_o            = ex_q;
    assign branch_target_o = ex_q.branch_target;
    assign pc_source_o     = ex_q.pc_source;

endmodule

/* verif/tb_ex_stage.sv */
/*
 * Directed testbench for the execute stage
 * ALU model, typed compare tasks and a cycle limit
 */

`include "ex_macros.svh"

module tb_ex_stage;

    localparam int CLK_HALF   = 50;
    localparam int DRIVE_DLY  = 10;
    // Tests need under 200 cycles
    localparam int MAX_CYCLES = 400;

    logic                clk_i;
    logic                rst_n_i;
    ex_pkg::id_ex_t      id_i;
    logic                stall_i;
    logic                flush_i;
    logic [`EX_XLEN-1:0] csr_rdata_i;
    ex_pkg::id_ex_t      ex_o;
    logic [`EX_XLEN-1:0] alu_result_o;
    ex_pkg::csr_req_t    csr_o;
    logic                branch_decision_o;
    logic [`EX_XLEN-1:0] branch_target_o;
    ex_pkg::pc_source_t  pc_source_o;
    logic                trap_o;

    integer seed;
    int     cycle_cnt;

    ex_stage #(.C_EXT(1'b0)) uut (.*);

    always #CLK_HALF clk_i = ~clk_i;

    //////////////////////////////
    // Failure and timeout
    //////////////////////////////

    task automatic abort_run();
        $display("Testbench failed");
        $fatal(1, "Run stopped at first failure");
    endtask

    always @(posedge clk_i) begin
        cycle_cnt = cycle_cnt + 1;
        if (cycle_cnt > MAX_CYCLES) begin
            $display("Timeout, tests did not finish within %0d cycles", MAX_CYCLES);
            abort_run();
        end
    end

    task automatic check_word(input string name, input logic [`EX_XLEN-1:0] exp,
                              input logic [`EX_XLEN-1:0] act);
        if (act !== exp) begin
            $display("ERROR %0t: %s expected %h actual %h", $time, name, exp, act);
            abort_run();
        end
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            $display("ERROR %0t: %s expected %b actual %b", $time, name, exp, act);
            abort_run();
        end
    endtask

    task automatic check_pc_source(input string name, input ex_pkg::pc_source_t exp,
                                   input ex_pkg::pc_source_t act);
        if (act !== exp) begin
            $display("ERROR %0t: %s expected %h actual %h", $time, name, exp, act);
            abort_run();
        end
    endtask

    task automatic check_id_ex(input string name, input ex_pkg::id_ex_t exp,
                               input ex_pkg::id_ex_t act);
        if (act !== exp) begin
            $display("ERROR %0t: %s expected %h actual %h", $time, name, exp, act);
            abort_run();
        end
    endtask

    task automatic check_csr_req(input string name, input ex_pkg::csr_req_t exp,
                                 input ex_pkg::csr_req_t act);
        if (act !== exp) begin
            $display("ERROR %0t: %s expected %h actual %h", $time, name, exp, act);
            abort_run();
        end
    endtask

    //////////////////////////////
    // Timing and stimulus helpers
    //////////////////////////////

    // Inputs change just after the rising edge
    task automatic next_drive_point();
        @(posedge clk_i);
        #DRIVE_DLY;
    endtask

    // Outputs read mid-cycle
    task automatic wait_sample_point();
        @(negedge clk_i);
    endtask

    // Same as the reset state of the register
    function automatic ex_pkg::id_ex_t idle_bundle();
        ex_pkg::id_ex_t bnd;
        bnd                = '0;
        bnd.mem.data_type  = ex_pkg::WORD;
        bnd.pc_source      = ex_pkg::PC_NEXT;
        bnd.csr_op         = ex_pkg::CSR_READ;
        return bnd;
    endfunction

    function automatic ex_pkg::id_ex_t op_bundle(input ex_pkg::alu_op_t op,
                                                 input logic [`EX_XLEN-1:0] a,
                                                 input logic [`EX_XLEN-1:0] b);
        ex_pkg::id_ex_t bnd;
        bnd             = idle_bundle();
        bnd.alu_op      = op;
        bnd.op1         = a;
        bnd.op2.word    = b;
        bnd.reg_alu_wen = 1'b1;
        bnd.valid       = 1'b1;
        return bnd;
    endfunction

    // Reference ALU with compare results in bit 0
    function automatic logic [`EX_XLEN-1:0] alu_model(input ex_pkg::alu_op_t op,
                                                      input logic [`EX_XLEN-1:0] a,
                                                      input logic [`EX_XLEN-1:0] b);
        logic [`EX_XLEN-1:0] r;
        logic [`EX_SHAMT_W-1:0] sh;
        logic slt;
        logic ult;
        sh  = b[`EX_SHAMT_W-1:0];
        ult = a < b;
        // When the sign bits differ the negative one is smaller
        slt = (a[`EX_XLEN-1] != b[`EX_XLEN-1]) ? a[`EX_XLEN-1] : ult;
        r   = '0;
        case (op)
            ex_pkg::ALU_ADD: r = a + b;
            ex_pkg::ALU_SUB: r = a - b;
            ex_pkg::ALU_AND: r = a & b;
            ex_pkg::ALU_OR:  r = a | b;
            ex_pkg::ALU_XOR: r = a ^ b;
            ex_pkg::ALU_SLL: r = a << sh;
            ex_pkg::ALU_SRL: r = a >> sh;
            // Logical shift and then refill the top with the sign
            ex_pkg::ALU_SRA: r = (a >> sh) |
                ({`EX_XLEN{a[`EX_XLEN-1]}} & ~({`EX_XLEN{1'b1}} >> sh));
            ex_pkg::ALU_SLT, ex_pkg::ALU_LT:   r[0] = slt;
            ex_pkg::ALU_SLTU, ex_pkg::ALU_LTU: r[0] = ult;
            ex_pkg::ALU_GE:  r[0] = !slt;
            ex_pkg::ALU_GEU: r[0] = !ult;
            ex_pkg::ALU_EQ:  r[0] = (a == b);
            ex_pkg::ALU_NE:  r[0] = (a != b);
            default:         r = a + b;
        endcase
        return r;
    endfunction

    //////////////////////////////
    // Directed tests
    //////////////////////////////

    task automatic verify_reset();
        ex_pkg::csr_req_t csr_exp;
        csr_exp = '0;
        wait_sample_point();
        check_id_ex("ex_o", idle_bundle(), ex_o);
        check_csr_req("csr_o", csr_exp, csr_o);
        check_bit("branch_decision_o", 1'b0, branch_decision_o);
        check_bit("trap_o", 1'b0, trap_o);
        next_drive_point();
    endtask

    // Second round uses equal operands for the compares
    task automatic sweep_alu_ops();
        ex_pkg::alu_op_t     op;
        logic [`EX_XLEN-1:0] a;
        logic [`EX_XLEN-1:0] b;
        for (int round = 0; round < 2; round++) begin
            for (int i = 0; i < 2**`EX_ALU_OP_W; i++) begin
                op   = ex_pkg::alu_op_t'(i);
                a    = $random(seed);
                b    = (round == 1) ? a : $random(seed);
                id_i = op_bundle(op, a, b);
                next_drive_point();
                wait_sample_point();
                check_word("alu_result_o", alu_model(op, a, b), alu_result_o);
                next_drive_point();
            end
        end
    endtask

    task automatic hold_and_bubble();
        ex_pkg::id_ex_t held;
        ex_pkg::id_ex_t bubble;
        held               = op_bundle(ex_pkg::ALU_XOR, $random(seed), $random(seed));
        held.rd_addr       = 5'd17;
        held.pc            = $random(seed);
        held.mem.req       = 1'b1;
        held.mem.wen       = 1'b1;
        held.mem.wdata     = $random(seed);
        held.reg_mem_wen   = 1'b1;
        held.pc_source     = ex_pkg::PC_JUMP;
        held.is_branch     = 1'b1;
        held.csr_access    = 1'b1;
        held.csr_op        = ex_pkg::CSR_WRITE;
        id_i = held;
        next_drive_point();
        // New bundle offered while stalled
        stall_i = 1'b1;
        id_i    = op_bundle(ex_pkg::ALU_SUB, $random(seed), $random(seed));
        repeat (2) begin
            wait_sample_point();
            check_id_ex("ex_o", held, ex_o);
            check_pc_source("pc_source_o", ex_pkg::PC_JUMP, pc_source_o);
            next_drive_point();
        end
        stall_i = 1'b0;
        flush_i = 1'b1;
        next_drive_point();
        // Bubble clears only the side-effect fields
        bubble             = held;
        bubble.valid       = 1'b0;
        bubble.mem.req     = 1'b0;
        bubble.mem.wen     = 1'b0;
        bubble.reg_alu_wen = 1'b0;
        bubble.reg_mem_wen = 1'b0;
        bubble.is_branch   = 1'b0;
        bubble.csr_access  = 1'b0;
        bubble.csr_op      = ex_pkg::CSR_READ;
        wait_sample_point();
        check_id_ex("ex_o", bubble, ex_o);
        next_drive_point();
        flush_i = 1'b0;
        id_i    = idle_bundle();
    endtask

    task automatic csr_read_capture();
        ex_pkg::id_ex_t      bnd;
        ex_pkg::csr_req_t    exp;
        logic [`EX_XLEN-1:0] rd_first;
        bnd            = op_bundle(ex_pkg::ALU_ADD, $random(seed), $random(seed));
        bnd.csr_access = 1'b1;
        bnd.csr_op     = ex_pkg::CSR_SET;
        bnd.pc         = $random(seed);
        exp.access     = 1'b1;
        exp.op         = ex_pkg::CSR_SET;
        exp.addr       = bnd.op2.word[`EX_CSR_ADDR_W-1:0];
        exp.wdata      = bnd.op1;
        exp.pc         = bnd.pc;
        id_i = bnd;
        next_drive_point();
        // Read data passes through live in the first access cycle
        rd_first    = $random(seed);
        csr_rdata_i = rd_first;
        stall_i     = 1'b1;
        id_i        = idle_bundle();
        wait_sample_point();
        check_csr_req("csr_o", exp, csr_o);
        check_word("alu_result_o", rd_first, alu_result_o);
        next_drive_point();
        csr_rdata_i = ~rd_first;
        wait_sample_point();
        check_word("alu_result_o", rd_first, alu_result_o);
        next_drive_point();
        stall_i     = 1'b0;
        csr_rdata_i = '0;
        next_drive_point();
        // Address and write data hold without an access
        exp.access = 1'b0;
        exp.op     = ex_pkg::CSR_READ;
        exp.pc     = '0;
        wait_sample_point();
        check_csr_req("csr_o", exp, csr_o);
        next_drive_point();
    endtask

    task automatic branch_case(input ex_pkg::alu_op_t op, input logic [`EX_XLEN-1:0] a,
                               input logic [`EX_XLEN-1:0] b,
                               input logic [`EX_XLEN-1:0] target, input logic valid);
        ex_pkg::id_ex_t      bnd;
        logic [`EX_XLEN-1:0] ref_res;
        logic                taken;
        bnd               = op_bundle(op, a, b);
        bnd.valid         = valid;
        bnd.reg_alu_wen   = 1'b0;
        bnd.is_branch     = 1'b1;
        bnd.branch_target = target;
        bnd.pc_source     = ex_pkg::PC_BRANCH;
        ref_res = alu_model(op, a, b);
        taken   = ref_res[0];
        id_i = bnd;
        next_drive_point();
        wait_sample_point();
        check_bit("branch_decision_o", taken, branch_decision_o);
        check_word("branch_target_o", target, branch_target_o);
        check_pc_source("pc_source_o", ex_pkg::PC_BRANCH, pc_source_o);
        // Without compressed instructions bit 1 of a taken target traps
        check_bit("trap_o", valid && taken && target[1], trap_o);
        next_drive_point();
    endtask

    task automatic branch_compare();
        logic [`EX_XLEN-1:0] a;
        logic [`EX_XLEN-1:0] b;
        for (int i = 0; i < 4; i++) begin
            a = $random(seed);
            b = i[1] ? a : $random(seed);
            branch_case(i[0] ? ex_pkg::ALU_LT : ex_pkg::ALU_EQ, a, b,
                        $random(seed) & ~32'h3, 1'b1);
        end
    endtask

    // Taken and misaligned, aligned, not taken, invalid slot
    task automatic misaligned_trap();
        logic [`EX_XLEN-1:0] a;
        logic [`EX_XLEN-1:0] tgt;
        a   = $random(seed);
        tgt = $random(seed);
        branch_case(ex_pkg::ALU_EQ, a, a, tgt | 32'h2, 1'b1);
        branch_case(ex_pkg::ALU_EQ, a, a, tgt & ~32'h3, 1'b1);
        branch_case(ex_pkg::ALU_EQ, a, a + 1, tgt | 32'h2, 1'b1);
        branch_case(ex_pkg::ALU_EQ, a, a, tgt | 32'h2, 1'b0);
    endtask

    initial begin
        seed        = 32'hafd0;
        cycle_cnt   = 0;
        clk_i       = 1'b0;
        rst_n_i     = 1'b0;
        id_i        = idle_bundle();
        stall_i     = 1'b0;
        flush_i     = 1'b0;
        csr_rdata_i = '0;
        repeat (4) @(posedge clk_i);
        #DRIVE_DLY;
        rst_n_i = 1'b1;
        verify_reset();
        sweep_alu_ops();
        hold_and_bubble();
        csr_read_capture();
        branch_compare();
        misaligned_trap();
        $display("Testbench passed");
        $finish;
    end

endmodule

/* ex_stage.f */
+incdir+logic
logic/ex_pkg.sv
logic/ex_pipe_reg.sv
logic/ex_alu.sv
logic/ex_resolve.sv
logic/ex_stage.sv
verif/tb_ex_stage.sv

/* Bender.yml */
package:
  name: ex_stage

sources:
  - include_dirs:
      - logic
    files:
      - logic/ex_pkg.sv
      - logic/ex_pipe_reg.sv
      - logic/ex_alu.sv
      - logic/ex_resolve.sv
      - logic/ex_stage.sv
  - target: test
    include_dirs:
      - logic
    files:
      - verif/tb_ex_stage.sv
